// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = rv_slice_tb
FILELIST  = rv_slice.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

# The run's exit status is ignored, the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/rv_alu_stage.sv
`default_nettype none

module rv_alu_stage
	import rv_slice_pkg::*;
(
	input  wire logic                      i_clock,
	input  wire logic                      i_reset,
	input  wire logic                      i_dec_valid,
	input  wire logic [REG_INDEX_BITS-1:0] i_rd_index,
	input  var  alu_op_e                   i_alu_op,
	input  wire logic [XLEN-1:0]           i_imm,
	input  wire logic                      i_use_imm,
	input  wire logic                      i_writes_rd,
	input  wire logic [XLEN-1:0]           i_rs1_data,
	input  wire logic [XLEN-1:0]           i_rs2_data,
	output logic                           o_alu_valid,
	output logic [REG_INDEX_BITS-1:0]      o_alu_rd,
	output logic [XLEN-1:0]                o_alu_result,
	output logic                           o_alu_writes_rd
);
	// Decode control delayed to meet the register file data
	logic                      ctl_valid;
	logic [REG_INDEX_BITS-1:0] ctl_rd;
	alu_op_e                   ctl_op;
	logic [XLEN-1:0]           ctl_imm;
	logic                      ctl_use_imm;
	logic                      ctl_writes_rd;

	logic [XLEN-1:0]       op_b;
	logic [SHAMT_BITS-1:0] shamt;
	logic [XLEN-1:0]       result;

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			ctl_valid     <= 1'b0;
			ctl_writes_rd <= 1'b0;
		end else begin
			ctl_valid     <= i_dec_valid;
			ctl_writes_rd <= i_writes_rd;
		end
	end

	always_ff @(posedge i_clock) begin
		ctl_rd      <= i_rd_index;
		ctl_op      <= i_alu_op;
		ctl_imm     <= i_imm;
		ctl_use_imm <= i_use_imm;
	end

	assign op_b  = ctl_use_imm ? ctl_imm : i_rs2_data;
	assign shamt = op_b[SHAMT_BITS-1:0];

	always_comb begin
		case (ctl_op)
			ALU_ADD:  result = i_rs1_data + op_b;
			ALU_SUB:  result = i_rs1_data - op_b;
			ALU_SLL:  result = i_rs1_data << shamt;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(i_rs1_data) < $signed(op_b)};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, i_rs1_data < op_b};
			ALU_XOR:  result = i_rs1_data ^ op_b;
			ALU_SRL:  result = i_rs1_data >> shamt;
			ALU_SRA:  result = $signed(i_rs1_data) >>> shamt;
			ALU_OR:   result = i_rs1_data | op_b;
			ALU_AND:  result = i_rs1_data & op_b;
			default:  result = op_b;  // ALU_PASS_B
		endcase
	end

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_alu_valid     <= 1'b0;
			o_alu_writes_rd <= 1'b0;
		end else begin
			o_alu_valid     <= ctl_valid;
			o_alu_writes_rd <= ctl_valid && ctl_writes_rd;
		end
	end

	always_ff @(posedge i_clock) begin
		o_alu_rd     <= ctl_rd;
		o_alu_result <= result;
	end

endmodule

`default_nettype wire

// File: logic/rv_inst_decoder.sv
`default_nettype none

module rv_inst_decoder
	import rv_slice_pkg::*;
(
	input  wire logic                      i_clock,
	input  wire logic                      i_reset,
	input  wire logic                      i_inst_valid,
	input  wire logic [XLEN-1:0]           i_inst,
	output logic                           o_dec_valid,
	output logic                           o_illegal,
	output logic [REG_INDEX_BITS-1:0]      o_rs1_index,
	output logic [REG_INDEX_BITS-1:0]      o_rs2_index,
	output logic [REG_INDEX_BITS-1:0]      o_rd_index,
	output alu_op_e                        o_alu_op,
	output logic [XLEN-1:0]                o_imm,
	output logic                           o_use_imm,
	output logic                           o_writes_rd
);
	opcode_e                   opcode;
	logic [2:0]                funct3;
	logic                      funct7_alt;  // Bit 30 picks SUB and SRA
	logic [REG_INDEX_BITS-1:0] inst_rd;
	logic [REG_INDEX_BITS-1:0] inst_rs1;
	alu_op_e                   funct_op;
	alu_op_e                   inst_op;
	logic [XLEN-1:0]           inst_imm;
	logic                      inst_use_imm;
	logic                      inst_legal;

	assign opcode     = opcode_e'(i_inst[6:0]);
	assign funct3     = i_inst[14:12];
	assign funct7_alt = i_inst[30];
	assign inst_rd    = i_inst[11:7];

	always_comb begin
		case (funct3)
			3'b000:  funct_op = (funct7_alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
			3'b001:  funct_op = ALU_SLL;
			3'b010:  funct_op = ALU_SLT;
			3'b011:  funct_op = ALU_SLTU;
			3'b100:  funct_op = ALU_XOR;
			3'b101:  funct_op = funct7_alt ? ALU_SRA : ALU_SRL;
			3'b110:  funct_op = ALU_OR;
			default: funct_op = ALU_AND;
		endcase
	end

	always_comb begin
		inst_legal   = 1'b1;
		inst_op      = funct_op;
		inst_imm     = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};  // I-type
		inst_use_imm = 1'b0;
		inst_rs1     = i_inst[19:15];
		case (opcode)
			OPC_OP: inst_use_imm = 1'b0;
			OPC_OP_IMM: inst_use_imm = 1'b1;
			OPC_LUI: begin
				inst_op      = ALU_PASS_B;
				inst_imm     = {i_inst[31:12], 12'h000};
				inst_use_imm = 1'b1;
				inst_rs1     = '0;
			end
			default: begin
				// Pass a zero immediate so the result comes out as zero
				inst_legal   = 1'b0;
				inst_op      = ALU_PASS_B;
				inst_imm     = '0;
				inst_use_imm = 1'b1;
			end
		endcase
	end

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_dec_valid <= 1'b0;
			o_illegal   <= 1'b0;
			o_writes_rd <= 1'b0;
		end else begin
			o_dec_valid <= i_inst_valid;
			o_illegal   <= i_inst_valid && !inst_legal;
			o_writes_rd <= i_inst_valid && inst_legal && (inst_rd != '0);
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_inst_valid) begin
			o_rs1_index <= inst_rs1;
			o_rs2_index <= i_inst[24:20];
			o_rd_index  <= inst_rd;
			o_alu_op    <= inst_op;
			o_imm       <= inst_imm;
			o_use_imm   <= inst_use_imm;
		end
	end

endmodule

`default_nettype wire

// File: logic/rv_register_file.sv
`default_nettype none

module rv_register_file
	import rv_slice_pkg::*;
(
	input  wire logic                      i_clock,
	input  wire logic                      i_reset,
	input  wire logic [REG_INDEX_BITS-1:0] i_rs1_index,
	input  wire logic [REG_INDEX_BITS-1:0] i_rs2_index,
	input  wire logic                      i_wb_tag,
	input  wire logic [REG_INDEX_BITS-1:0] i_wb_rd,
	input  wire logic [XLEN-1:0]           i_wb_data,
	output logic [XLEN-1:0]                o_rs1_data,
	output logic [XLEN-1:0]                o_rs2_data
);
	logic [XLEN-1:0] regs [REG_COUNT];
	logic            write_tag;  // Tag of the last write taken
	logic            tag_changed;

	assign tag_changed = (i_wb_tag != write_tag);

	// Read first, write later: a read in the same cycle as a write gets the old value
	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_rs1_data <= '0;
			o_rs2_data <= '0;
			write_tag  <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= (i == SP_INDEX) ? STACK_POINTER : '0;
			end
		end else begin
			o_rs1_data <= (i_rs1_index != '0) ? regs[i_rs1_index] : '0;
			o_rs2_data <= (i_rs2_index != '0) ? regs[i_rs2_index] : '0;

			if (tag_changed) begin
				if (i_wb_rd != '0)  // x0 stays zero
					regs[i_wb_rd] <= i_wb_data;
				write_tag <= i_wb_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/rv_slice_pkg.sv
`default_nettype none

package rv_slice_pkg;

	localparam int XLEN           = 32;
	localparam int REG_COUNT      = 32;
	localparam int REG_INDEX_BITS = $clog2(REG_COUNT);
	localparam int SHAMT_BITS     = 5;  // Shift amount taken from operand B
	localparam int OPCODE_BITS    = 7;
	localparam int ALU_OP_BITS    = 4;

	// Register reset values
	localparam logic [XLEN-1:0] STACK_POINTER = 32'h0000_8000;
	localparam int              SP_INDEX      = 2;

	// Major opcodes handled by this slice, anything else is illegal
	typedef enum logic [OPCODE_BITS-1:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [ALU_OP_BITS-1:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10  // LUI, result is the U immediate
	} alu_op_e;

endpackage

`default_nettype wire

// File: logic/rv_slice_top.sv
`default_nettype none

module rv_slice_top
	import rv_slice_pkg::*;
(
	input  wire logic                      i_clock,
	input  wire logic                      i_reset,
	input  wire logic                      i_inst_valid,
	input  wire logic [XLEN-1:0]           i_inst,
	output logic                           o_illegal,
	output logic                           o_result_valid,
	output logic [REG_INDEX_BITS-1:0]      o_result_rd,
	output logic [XLEN-1:0]                o_result_data
);
	logic                      dec_valid;
	logic [REG_INDEX_BITS-1:0] dec_rs1_index;
	logic [REG_INDEX_BITS-1:0] dec_rs2_index;
	logic [REG_INDEX_BITS-1:0] dec_rd_index;
	alu_op_e                   dec_alu_op;
	logic [XLEN-1:0]           dec_imm;
	logic                      dec_use_imm;
	logic                      dec_writes_rd;

	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;

	logic                      alu_valid;
	logic [REG_INDEX_BITS-1:0] alu_rd;
	logic [XLEN-1:0]           alu_result;
	logic                      alu_writes_rd;

	logic                      wb_tag;
	logic [REG_INDEX_BITS-1:0] wb_rd;
	logic [XLEN-1:0]           wb_data;

	rv_inst_decoder u_decoder (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_inst_valid (i_inst_valid),
		.i_inst       (i_inst),
		.o_dec_valid  (dec_valid),
		.o_illegal    (o_illegal),
		.o_rs1_index  (dec_rs1_index),
		.o_rs2_index  (dec_rs2_index),
		.o_rd_index   (dec_rd_index),
		.o_alu_op     (dec_alu_op),
		.o_imm        (dec_imm),
		.o_use_imm    (dec_use_imm),
		.o_writes_rd  (dec_writes_rd)
	);

	rv_register_file u_register_file (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_rs1_index (dec_rs1_index),
		.i_rs2_index (dec_rs2_index),
		.i_wb_tag    (wb_tag),
		.i_wb_rd     (wb_rd),
		.i_wb_data   (wb_data),
		.o_rs1_data  (rs1_data),
		.o_rs2_data  (rs2_data)
	);

	rv_alu_stage u_alu_stage (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_dec_valid     (dec_valid),
		.i_rd_index      (dec_rd_index),
		.i_alu_op        (dec_alu_op),
		.i_imm           (dec_imm),
		.i_use_imm       (dec_use_imm),
		.i_writes_rd     (dec_writes_rd),
		.i_rs1_data      (rs1_data),
		.i_rs2_data      (rs2_data),
		.o_alu_valid     (alu_valid),
		.o_alu_rd        (alu_rd),
		.o_alu_result    (alu_result),
		.o_alu_writes_rd (alu_writes_rd)
	);

	rv_writeback_stage u_writeback_stage (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_alu_valid     (alu_valid),
		.i_alu_rd        (alu_rd),
		.i_alu_result    (alu_result),
		.i_alu_writes_rd (alu_writes_rd),
		.o_result_valid  (o_result_valid),
		.o_result_rd     (o_result_rd),
		.o_result_data   (o_result_data),
		.o_wb_tag        (wb_tag),
		.o_wb_rd         (wb_rd),
		.o_wb_data       (wb_data)
	);

endmodule

`default_nettype wire

// File: logic/rv_writeback_stage.sv
`default_nettype none

module rv_writeback_stage
	import rv_slice_pkg::*;
(
	input  wire logic                      i_clock,
	input  wire logic                      i_reset,
	input  wire logic                      i_alu_valid,
	input  wire logic [REG_INDEX_BITS-1:0] i_alu_rd,
	input  wire logic [XLEN-1:0]           i_alu_result,
	input  wire logic                      i_alu_writes_rd,
	output logic                           o_result_valid,
	output logic [REG_INDEX_BITS-1:0]      o_result_rd,
	output logic [XLEN-1:0]                o_result_data,
	output logic                           o_wb_tag,
	output logic [REG_INDEX_BITS-1:0]      o_wb_rd,
	output logic [XLEN-1:0]                o_wb_data
);
	logic take_write;

	assign take_write = i_alu_valid && i_alu_writes_rd;

	always_ff @(posedge i_clock, posedge i_reset) begin
		if (i_reset) begin
			o_result_valid <= 1'b0;
			o_wb_tag       <= 1'b0;
		end else begin
			o_result_valid <= i_alu_valid;
			if (take_write)
				o_wb_tag <= !o_wb_tag;  // Register file writes on the change
		end
	end

	// Illegal instructions arrive here with a zero result already
	always_ff @(posedge i_clock) begin
		if (i_alu_valid) begin
			o_result_rd   <= i_alu_rd;
			o_result_data <= i_alu_result;
		end
		if (take_write) begin
			o_wb_rd   <= i_alu_rd;
			o_wb_data <= i_alu_result;
		end
	end

endmodule

`default_nettype wire

// File: rv_slice.f
logic/rv_slice_pkg.sv
logic/rv_inst_decoder.sv
logic/rv_register_file.sv
logic/rv_alu_stage.sv
logic/rv_writeback_stage.sv
logic/rv_slice_top.sv
verif/rv_slice_properties.sv
verif/rv_slice_tb.sv

// File: verif/rv_slice_properties.sv
`default_nettype none

module rv_slice_properties
	import rv_slice_pkg::*;
(
	input wire logic                      i_clock,
	input wire logic                      i_reset,
	input wire logic                      i_inst_valid,
	input wire logic                      o_illegal,
	input wire logic                      o_result_valid,
	input wire logic [REG_INDEX_BITS-1:0] o_result_rd,
	input wire logic [XLEN-1:0]           o_result_data
);
	timeunit 1ns;
	timeprecision 1ps;

	int failure_count = 0;

	// Result comes exactly four cycles after the strobe, in both directions
	assert property (@(posedge i_clock) disable iff (i_reset)
		$past(i_inst_valid, 4) |-> o_result_valid)
	else begin
		failure_count++;
		$error("o_result_valid missing four cycles after i_inst_valid");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_result_valid |-> $past(i_inst_valid, 4))
	else begin
		failure_count++;
		$error("o_result_valid without i_inst_valid four cycles earlier");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_illegal |-> $past(i_inst_valid))
	else begin
		failure_count++;
		$error("o_illegal without a decode one cycle earlier");
	end

	assert property (@(posedge i_clock) disable iff (i_reset)
		o_result_valid |-> !$isunknown({o_result_rd, o_result_data}))
	else begin
		failure_count++;
		$error("Unknown result outputs while o_result_valid is high");
	end

	assert property (@(posedge i_clock) i_reset |-> !o_result_valid && !o_illegal)
	else begin
		failure_count++;
		$error("Valid output high during reset");
	end

endmodule

`default_nettype wire

// File: verif/rv_slice_tb.sv
`default_nettype none

module rv_slice_tb
	import rv_slice_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef logic [REG_INDEX_BITS-1:0] reg_index_t;

	localparam int CLOCK_PERIOD  = 100;
	localparam int DRIVE_DELAY   = 5;
	localparam int RESET_CYCLES  = 16;
	localparam int LATENCY       = 4;
	localparam int RAND_COUNT    = 200;
	localparam int LUI_COUNT     = 30;
	localparam int BURST_COUNT   = 30;
	localparam int ILLEGAL_COUNT = 40;
	// Worst case length of all tests with every gap at its longest
	localparam int TOTAL_CYCLES = RESET_CYCLES + REG_COUNT + RAND_COUNT * 7 + LUI_COUNT * 12
		+ BURST_COUNT * 14 + ILLEGAL_COUNT * 4 + REG_COUNT + 5 * LATENCY;

	logic            i_clock;
	logic            i_reset;
	logic            i_inst_valid;
	logic [XLEN-1:0] i_inst;
	logic            o_illegal;
	logic            o_result_valid;
	reg_index_t      o_result_rd;
	logic [XLEN-1:0] o_result_data;

	logic [XLEN-1:0] model_regs [REG_COUNT];
	// Instructions in flight with the oldest at index 3
	logic            pend_valid  [LATENCY];
	logic            pend_writes [LATENCY];
	reg_index_t      pend_rd     [LATENCY];
	logic [XLEN-1:0] pend_data   [LATENCY];
	logic            last_illegal;

	int seed = 19631;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_errors = 0;
	int test_checks = 0;

	rv_slice_top i_dut (.*);

	bind rv_slice_top rv_slice_properties u_properties (.*);

	initial begin
		i_clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) i_clock = !i_clock;
	end

	initial begin
		#((TOTAL_CYCLES + 20) * CLOCK_PERIOD);
		$display("Timeout: run did not end within %0d clock cycles", TOTAL_CYCLES + 20);
		$display("tests failed");
		$finish;
	end

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [XLEN-1:0] r_type_word(logic [6:0] funct7, reg_index_t rs2,
		reg_index_t rs1, logic [2:0] funct3, reg_index_t rd);
		return {funct7, rs2, rs1, funct3, rd, OPC_OP};
	endfunction

	function automatic logic [XLEN-1:0] i_type_word(logic [11:0] imm, reg_index_t rs1,
		logic [2:0] funct3, reg_index_t rd);
		return {imm, rs1, funct3, rd, OPC_OP_IMM};
	endfunction

	function automatic logic [XLEN-1:0] u_type_word(logic [19:0] imm, reg_index_t rd);
		return {imm, rd, OPC_LUI};
	endfunction

	// Legal R or I type word for one of the ten ALU operations
	function automatic logic [XLEN-1:0] random_alu_inst(reg_index_t reg_mask);
		logic [31:0] r;
		logic [11:0] imm;
		logic        alt;
		r   = next_random();
		imm = 12'(next_random());
		alt = r[18] && (r[17:15] == 3'b000 || r[17:15] == 3'b101);
		if (r[19])
			return r_type_word({1'b0, alt, 5'b0}, r[14:10] & reg_mask, r[9:5] & reg_mask,
				r[17:15], r[4:0] & reg_mask);
		if (r[17:15] == 3'b001)
			imm[11:5] = 7'b0;
		else if (r[17:15] == 3'b101)
			imm[11:5] = {1'b0, alt, 5'b0};  // SRLI or SRAI
		return i_type_word(imm, r[9:5] & reg_mask, r[17:15], r[4:0] & reg_mask);
	endfunction

	function automatic logic [XLEN-1:0] alu_model(logic [2:0] funct3, logic alt,
		logic [XLEN-1:0] a, logic [XLEN-1:0] b);
		case (funct3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
			3'b011:  return (a < b) ? XLEN'(1) : '0;
			3'b100:  return a ^ b;
			3'b101:  return alt ? XLEN'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic model_execute(input logic [XLEN-1:0] inst, output logic [XLEN-1:0] result,
		output logic writes, output logic illegal);
		logic [XLEN-1:0] imm_i;
		imm_i   = XLEN'($signed(inst[31:20]));
		result  = '0;
		illegal = 1'b0;
		case (inst[6:0])
			OPC_OP: result = alu_model(inst[14:12], inst[30], model_regs[inst[19:15]],
				model_regs[inst[24:20]]);
			OPC_OP_IMM: result = alu_model(inst[14:12], inst[30] && inst[14:12] == 3'b101,
				model_regs[inst[19:15]], imm_i);
			OPC_LUI: result = XLEN'(inst[31:12]) << 12;
			default: illegal = 1'b1;
		endcase
		writes = !illegal && inst[11:7] != '0;  // x0 is never written
	endtask

	task automatic check_result(input reg_index_t got_rd, input reg_index_t exp_rd,
		input logic [XLEN-1:0] got_data, input logic [XLEN-1:0] exp_data);
		check_count++;
		if (got_rd !== exp_rd || got_data !== exp_data) begin
			error_count++;
			$display("** Error: o_result_rd = %h, o_result_data = %h, expected %h, %h at %0t",
				got_rd, got_data, exp_rd, exp_data, $time);
		end
	endtask

	task automatic check_illegal(input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("** Error: o_illegal = %h, expected %h at %0t", got, exp, $time);
		end
	endtask

	// One clock of stimulus that also checks what earlier strobes produced
	task automatic drive_cycle(input logic valid, input logic [XLEN-1:0] inst);
		logic [XLEN-1:0] result;
		logic            writes;
		logic            illegal;
		@(posedge i_clock);
		#DRIVE_DELAY;
		check_illegal(o_illegal, last_illegal);
		if (o_result_valid !== pend_valid[LATENCY-1]) begin
			error_count++;
			if (pend_valid[LATENCY-1])
				$display("Missing o_result_valid four cycles after a strobe at %0t", $time);
			else
				$display("Extra o_result_valid with no instruction in flight at %0t", $time);
		end else if (pend_valid[LATENCY-1]) begin
			check_result(o_result_rd, pend_rd[LATENCY-1], o_result_data, pend_data[LATENCY-1]);
		end
		if (pend_writes[LATENCY-1])
			model_regs[pend_rd[LATENCY-1]] = pend_data[LATENCY-1];
		for (int i = LATENCY - 1; i > 0; i--) begin
			pend_valid[i]  = pend_valid[i-1];
			pend_writes[i] = pend_writes[i-1];
			pend_rd[i]     = pend_rd[i-1];
			pend_data[i]   = pend_data[i-1];
		end
		model_execute(inst, result, writes, illegal);
		pend_valid[0]  = valid;
		pend_writes[0] = valid && writes;
		pend_rd[0]     = inst[11:7];
		pend_data[0]   = result;
		last_illegal   = valid && illegal;
		i_inst_valid   = valid;
		i_inst         = inst;
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) drive_cycle(1'b0, '0);
	endtask

	task automatic end_test(input string name);
		idle(LATENCY);
		test_count++;
		if (error_count == test_errors)
			$display("Test %0d %s: ok, %0d checks", test_count, name, check_count - test_checks);
		else
			$display("Test %0d %s: %0d errors", test_count, name, error_count - test_errors);
		test_errors = error_count;
		test_checks = check_count;
	endtask

	task automatic reset_state_test();
		for (int i = 0; i < REG_COUNT; i++) begin
			if (i != SP_INDEX)
				drive_cycle(1'b1, i_type_word(12'h000, reg_index_t'(i), 3'b000, 5'd0));
		end
		drive_cycle(1'b1, i_type_word(12'h000, reg_index_t'(SP_INDEX), 3'b000, 5'd5));
		end_test("reset state");
	endtask

	task automatic random_alu_test();
		logic [31:0] r;
		for (int n = 0; n < RAND_COUNT; n++) begin
			r = next_random();
			drive_cycle(1'b1, random_alu_inst(5'h1f));
			idle(3 + int'(r[1:0]));
		end
		end_test("random ALU");
	endtask

	task automatic lui_and_x0_test();
		logic [31:0] r;
		for (int n = 0; n < LUI_COUNT; n++) begin
			r = next_random();
			drive_cycle(1'b1, u_type_word(r[31:12], r[4:0]));
			idle(3);
			drive_cycle(1'b1, i_type_word(r[11:0], r[9:5], 3'b000, 5'd0));  // Aimed at x0
			idle(3);
			drive_cycle(1'b1, r_type_word(7'b0, 5'd0, 5'd0, 3'b110, r[14:10]));
			idle(3);
		end
		end_test("LUI and x0");
	endtask

	task automatic back_to_back_test();
		logic [31:0] r;
		reg_index_t  producer;
		for (int n = 0; n < BURST_COUNT; n++) begin
			r = next_random();
			producer = (r[4:0] == '0) ? 5'd1 : r[4:0];
			drive_cycle(1'b1, i_type_word({r[31:21], 1'b1}, producer, 3'b000, producer));
			// Readers 1 to 5 cycles behind where only the last two see the new value
			for (int k = 0; k < 5; k++)
				drive_cycle(1'b1, i_type_word(12'h000, producer, 3'b000, 5'd0));
			for (int k = 0; k < 8; k++)
				drive_cycle(1'b1, random_alu_inst(5'h03));
		end
		end_test("back to back");
	endtask

	task automatic illegal_opcode_test();
		logic [31:0] r;
		logic [6:0]  opcode;
		for (int n = 0; n < ILLEGAL_COUNT; n++) begin
			r = next_random();
			opcode = r[6:0];
			if (opcode == OPC_OP || opcode == OPC_OP_IMM || opcode == OPC_LUI)
				opcode[6] = 1'b1;
			drive_cycle(1'b1, {r[31:7], opcode});
			idle(int'(r[8:7]));
		end
		for (int i = 0; i < REG_COUNT; i++)
			drive_cycle(1'b1, i_type_word(12'h000, reg_index_t'(i), 3'b000, 5'd0));
		end_test("illegal opcodes");
	endtask

	initial begin
		i_reset      = 1'b1;
		i_inst_valid = 1'b0;
		i_inst       = '0;
		last_illegal = 1'b0;
		for (int i = 0; i < REG_COUNT; i++)
			model_regs[i] = (i == SP_INDEX) ? STACK_POINTER : '0;
		for (int i = 0; i < LATENCY; i++) begin
			pend_valid[i]  = 1'b0;
			pend_writes[i] = 1'b0;
			pend_rd[i]     = '0;
			pend_data[i]   = '0;
		end
		repeat (RESET_CYCLES) @(posedge i_clock);
		#DRIVE_DELAY;
		i_reset = 1'b0;

		reset_state_test();
		random_alu_test();
		lui_and_x0_test();
		back_to_back_test();
		illegal_opcode_test();

		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures", test_count,
			check_count, error_count, i_dut.u_properties.failure_count);
		if (error_count == 0 && i_dut.u_properties.failure_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
